//--- verilog.f
+incdir+verif
common/rv32_pkg.sv
common/ooo_pkg.sv
execute/fu_add.sv
execute/fu_mult.sv
execute/fu_div_rem.sv
execute/execute.sv
verif/tb_execute.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_execute \
    -f verilog.f -o tb_execute_sim || exit 1
out="$(./obj_dir/tb_execute_sim)"
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1

//--- verif/exec_model.svh
`ifndef exec_model_svh
`define exec_model_svh

// One result that a CDB port owes, with the cycle in which it must appear.
typedef struct packed {
    ooo_pkg::tag_t tag;
    logic [31:0]   value;
    int            due;
} exp_pkt_t;

localparam int unit_add = 0;
localparam int unit_mul = 1;
localparam int unit_div = 2;

exp_pkt_t exp_q [3][$];

function automatic logic [31:0] alu_ref(logic [31:0] a, logic [31:0] r2,
                                        rv32_pkg::decode_info_t info);
    logic [31:0] b;
    logic [4:0]  sh;
    b  = info.use_imm ? info.imm : r2;
    sh = b[4:0];
    case (info.op.alu)
        rv32_pkg::alu_add:  return (info.alt && !info.use_imm) ? a + ~b + 32'd1 : a + b;
        rv32_pkg::alu_sll:  return a << sh;
        rv32_pkg::alu_slt:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        rv32_pkg::alu_sltu: return {31'b0, a < b};
        rv32_pkg::alu_xor:  return a ^ b;
        rv32_pkg::alu_srl:  return (a >> sh) |
                                   ((info.alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
        rv32_pkg::alu_or:   return a | b;
        default:            return a & b;
    endcase
endfunction

function automatic logic [31:0] mul_ref(logic [31:0] a, logic [31:0] b, rv32_pkg::md_op_e op);
    logic [63:0] p;
    logic        sa;
    logic        sb;
    sa = (op == rv32_pkg::md_mulh) || (op == rv32_pkg::md_mulhsu);
    sb = (op == rv32_pkg::md_mulh);
    // Sign-extended 64-bit operands give the exact product modulo 2^64.
    p = {{32{sa & a[31]}}, a} * {{32{sb & b[31]}}, b};
    return (op == rv32_pkg::md_mul) ? p[31:0] : p[63:32];
endfunction

function automatic logic [31:0] div_ref(logic [31:0] a, logic [31:0] b, rv32_pkg::md_op_e op);
    logic   is_rem;
    logic   is_signed;
    longint na;
    longint nb;
    longint res;
    is_rem    = (op == rv32_pkg::md_rem) || (op == rv32_pkg::md_remu);
    is_signed = (op == rv32_pkg::md_div) || (op == rv32_pkg::md_rem);
    // RISC-V defines both of these results instead of trapping.
    if (b == 32'h0) begin
        return is_rem ? a : 32'hffff_ffff;
    end
    if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        return is_rem ? 32'h0 : a;
    end
    if (is_signed) begin
        na = longint'($signed(a));
        nb = longint'($signed(b));
    end else begin
        na = longint'(a);
        nb = longint'(b);
    end
    res = is_rem ? na % nb : na / nb;
    return res[31:0];
endfunction

`endif

//--- verif/tb_execute.sv
`timescale 1ns/1ps

module tb_execute;

    localparam int mul_stages  = 3;
    localparam int div_latency = 33;
    localparam int n_add       = 300;
    localparam int n_mul       = 200;
    localparam int n_div       = 40;
    localparam int n_dir       = 6;
    localparam int n_mix       = 8;
    localparam int n_divides   = n_div + n_dir + n_mix;
    localparam int cycle_limit = 20 + n_add + 2 * n_mul + (div_latency + 2) * n_divides
                                 + 40 * n_divides;

    logic                   clk;
    logic                   rst;
    logic [31:0]            rs1_v;
    logic [31:0]            rs2_v;
    rv32_pkg::decode_info_t info_add;
    rv32_pkg::decode_info_t info_mul;
    rv32_pkg::decode_info_t info_div;
    ooo_pkg::tag_t          tag_add;
    ooo_pkg::tag_t          tag_mul;
    ooo_pkg::tag_t          tag_div;
    logic                   start_add;
    logic                   start_mul;
    logic                   start_div;
    ooo_pkg::cdb_t          cdb_add;
    ooo_pkg::cdb_t          cdb_mul;
    ooo_pkg::cdb_t          cdb_div;
    logic                   div_busy;

    integer seed   = 19;
    int     cycle  = 0;
    int     errors = 0;
    int     checks = 0;
    int     test_errors = 0;

    `include "exec_model.svh"

    execute #(.mul_stages(mul_stages)) i_dut (
        .clk (clk), .rst (rst), .rs1_v (rs1_v), .rs2_v (rs2_v),
        .info_add (info_add), .info_mul (info_mul), .info_div (info_div),
        .tag_add (tag_add), .tag_mul (tag_mul), .tag_div (tag_div),
        .start_add (start_add), .start_mul (start_mul), .start_div (start_div),
        .cdb_add (cdb_add), .cdb_mul (cdb_mul), .cdb_div (cdb_div), .div_busy (div_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // Corner values show up often enough to hit the divider special cases.
    function automatic logic [31:0] random_operand();
        logic [31:0] r;
        r = random_word();
        case (r[3:0])
            4'd0:    return 32'h0;
            4'd1:    return 32'h8000_0000;
            4'd2:    return 32'hffff_ffff;
            4'd3:    return 32'h1;
            default: return random_word();
        endcase
    endfunction

    function automatic ooo_pkg::tag_t random_tag();
        logic [31:0] r;
        r = random_word();
        return r[$bits(ooo_pkg::tag_t)-1:0];
    endfunction

    task automatic next_slot();
        @(posedge clk);
        #2;
        start_add = 1'b0;
        start_mul = 1'b0;
        start_div = 1'b0;
    endtask

    task automatic issue_add();
        logic [31:0] r;
        exp_pkt_t    p;
        r = random_word();
        rs1_v = random_operand();
        rs2_v = random_operand();
        info_add.op.alu  = rv32_pkg::alu_op_e'(r[2:0]);
        info_add.use_imm = r[3];
        info_add.alt     = r[4] && (r[2:0] == 3'b101 || (r[2:0] == 3'b000 && !r[3]));
        info_add.imm     = {{20{r[16]}}, r[16:5]};
        tag_add   = random_tag();
        start_add = 1'b1;
        p.tag   = tag_add;
        p.value = alu_ref(rs1_v, rs2_v, info_add);
        p.due   = cycle + 1;
        exp_q[unit_add].push_back(p);
    endtask

    task automatic issue_mul();
        logic [31:0] r;
        exp_pkt_t    p;
        r = random_word();
        rs1_v = random_operand();
        rs2_v = random_operand();
        info_mul        = '0;
        info_mul.op.md  = rv32_pkg::md_op_e'({1'b0, r[1:0]});
        tag_mul   = random_tag();
        start_mul = 1'b1;
        p.tag   = tag_mul;
        p.value = mul_ref(rs1_v, rs2_v, info_mul.op.md);
        p.due   = cycle + mul_stages;
        exp_q[unit_mul].push_back(p);
    endtask

    task automatic issue_div(logic [31:0] a, logic [31:0] b, rv32_pkg::md_op_e op);
        exp_pkt_t p;
        rs1_v = a;
        rs2_v = b;
        info_div       = '0;
        info_div.op.md = op;
        tag_div   = random_tag();
        start_div = 1'b1;
        p.tag   = tag_div;
        p.value = div_ref(a, b, op);
        p.due   = cycle + div_latency;
        exp_q[unit_div].push_back(p);
    endtask

    task automatic wait_unit_idle(int unit);
        while (exp_q[unit].size() != 0) begin
            next_slot();
        end
    endtask

    task automatic finish_test(string name);
        $display("%s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Compares a CDB port with the oldest packet its unit still owes.
    task automatic check_port(int unit, string port, ooo_pkg::cdb_t got);
        exp_pkt_t exp;
        if (got.valid) begin
            assert (exp_q[unit].size() != 0) else begin
                $display("%s delivered a result in cycle %0d with none outstanding", port, cycle);
                errors++;
            end
            if (exp_q[unit].size() != 0) begin
                exp = exp_q[unit].pop_front();
                checks++;
                assert (got.tag == exp.tag) else begin
                    $display("MISMATCH %s.tag got %h expected %h", port, got.tag, exp.tag);
                    errors++;
                end
                assert (got.rd_v == exp.value) else begin
                    $display("MISMATCH %s.rd_v got %h expected %h", port, got.rd_v, exp.value);
                    errors++;
                end
                assert (cycle == exp.due) else begin
                    $display("%s result came in cycle %0d but was due in cycle %0d",
                             port, cycle, exp.due);
                    errors++;
                end
            end
        end else if (exp_q[unit].size() != 0) begin
            assert (exp_q[unit][0].due > cycle) else begin
                $display("%s result due in cycle %0d never came", port, exp_q[unit][0].due);
                errors++;
                exp = exp_q[unit].pop_front();
            end
        end
    endtask

    always @(negedge clk) begin
        logic busy_exp;
        if (!rst) begin
            busy_exp = 1'b0;
            if (exp_q[unit_div].size() != 0) begin
                busy_exp = cycle > exp_q[unit_div][0].due - div_latency &&
                           cycle < exp_q[unit_div][0].due;
            end
            assert (div_busy == busy_exp) else begin
                $display("MISMATCH div_busy got %h expected %h", div_busy, busy_exp);
                errors++;
            end
            check_port(unit_add, "cdb_add", cdb_add);
            check_port(unit_mul, "cdb_mul", cdb_mul);
            check_port(unit_div, "cdb_div", cdb_div);
        end
    end

    initial begin
        logic [31:0] r;
        int          issued;
        rst = 1'b1;
        rs1_v = '0;
        rs2_v = '0;
        info_add = '0;
        info_mul = '0;
        info_div = '0;
        tag_add = '0;
        tag_mul = '0;
        tag_div = '0;
        start_add = 1'b0;
        start_mul = 1'b0;
        start_div = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        assert (!cdb_add.valid && !cdb_mul.valid && !cdb_div.valid && !div_busy) else begin
            $display("a CDB valid or div_busy is high right after reset");
            errors++;
        end
        finish_test("reset_state");

        repeat (n_add) begin
            next_slot();
            issue_add();
        end
        wait_unit_idle(unit_add);
        finish_test("alu_random");

        issued = 0;
        while (issued < n_mul) begin
            next_slot();
            r = random_word();
            if (r[1:0] != 2'b00) begin
                issue_mul();
                issued++;
            end
        end
        wait_unit_idle(unit_mul);
        finish_test("mul_pipeline");

        repeat (n_div) begin
            next_slot();
            r = random_word();
            issue_div(random_operand(), random_operand(), rv32_pkg::md_op_e'({1'b1, r[1:0]}));
            wait_unit_idle(unit_div);
        end
        for (int k = 4; k < 8; k++) begin
            next_slot();
            issue_div(32'hf00d_1234, 32'h0, rv32_pkg::md_op_e'(k));
            wait_unit_idle(unit_div);
        end
        next_slot();
        issue_div(32'h8000_0000, 32'hffff_ffff, rv32_pkg::md_div);
        wait_unit_idle(unit_div);
        next_slot();
        issue_div(32'h8000_0000, 32'hffff_ffff, rv32_pkg::md_rem);
        wait_unit_idle(unit_div);
        finish_test("div_rem");

        // Other units start while the divider runs, and tag_div keeps changing.
        repeat (n_mix) begin
            next_slot();
            r = random_word();
            issue_div(random_operand(), random_operand(), rv32_pkg::md_op_e'({1'b1, r[1:0]}));
            while (exp_q[unit_div].size() != 0) begin
                next_slot();
                tag_div = random_tag();
                r = random_word();
                if (r[1:0] == 2'b01) begin
                    issue_add();
                end else if (r[1]) begin
                    issue_mul();
                end
            end
        end
        wait_unit_idle(unit_add);
        wait_unit_idle(unit_mul);
        finish_test("mixed_traffic");

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_execute

//--- execute/execute.sv
`timescale 1ns/1ps

module execute #(
    parameter int mul_stages = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            rs1_v,
    input  logic [31:0]            rs2_v,
    input  rv32_pkg::decode_info_t info_add,
    input  rv32_pkg::decode_info_t info_mul,
    input  rv32_pkg::decode_info_t info_div,
    input  ooo_pkg::tag_t          tag_add,
    input  ooo_pkg::tag_t          tag_mul,
    input  ooo_pkg::tag_t          tag_div,
    input  logic                   start_add,
    input  logic                   start_mul,
    input  logic                   start_div,
    output ooo_pkg::cdb_t          cdb_add,
    output ooo_pkg::cdb_t          cdb_mul,
    output ooo_pkg::cdb_t          cdb_div,
    output logic                   div_busy
);

    ooo_pkg::tag_t tag_add_q;
    ooo_pkg::tag_t tag_div_q;
    ooo_pkg::tag_t tag_mul_out;

    logic [31:0] rd_v_add;
    logic [31:0] rd_v_mul;
    logic [31:0] rd_v_div;
    logic        valid_add;
    logic        valid_mul;
    logic        valid_div;

    // The adder and divider hold one operation each, so their tags are
    // captured at start and held until the result goes out.
    always_ff @(posedge clk) begin
        if (start_add) begin
            tag_add_q <= tag_add;
        end
        if (start_div && !div_busy) begin
            tag_div_q <= tag_div;
        end
    end

    fu_add i_fu_add (
        .clk   (clk),
        .rst   (rst),
        .rs1_v (rs1_v),
        .rs2_v (rs2_v),
        .info  (info_add),
        .start (start_add),
        .rd_v  (rd_v_add),
        .valid (valid_add)
    );

    fu_mult #(
        .mul_stages (mul_stages)
    ) i_fu_mult (
        .clk     (clk),
        .rst     (rst),
        .rs1_v   (rs1_v),
        .rs2_v   (rs2_v),
        .info    (info_mul),
        .tag_in  (tag_mul),
        .start   (start_mul),
        .rd_v    (rd_v_mul),
        .tag_out (tag_mul_out),
        .valid   (valid_mul)
    );

    fu_div_rem i_fu_div_rem (
        .clk   (clk),
        .rst   (rst),
        .rs1_v (rs1_v),
        .rs2_v (rs2_v),
        .info  (info_div),
        .start (start_div),
        .rd_v  (rd_v_div),
        .valid (valid_div),
        .busy  (div_busy)
    );

    always_comb begin
        cdb_add.valid = valid_add;
        cdb_add.tag   = tag_add_q;
        cdb_add.rd_v  = rd_v_add;

        cdb_mul.valid = valid_mul;
        cdb_mul.tag   = tag_mul_out;
        cdb_mul.rd_v  = rd_v_mul;

        cdb_div.valid = valid_div;
        cdb_div.tag   = tag_div_q;
        cdb_div.rd_v  = rd_v_div;
    end

    // The units share the operand buses, so only one may start per cycle.
    a_one_start : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({start_add, start_mul, start_div})
    ) else $error("more than one unit started in the same cycle");

    // Divider is busy for 32 cycles and posts its result as busy drops.
    a_div_window : assert property (
        @(posedge clk) disable iff (rst)
        start_div |=> div_busy [*32] ##1 (cdb_div.valid && !div_busy)
    ) else $error("divider busy window or result timing is wrong");

endmodule : execute

//--- execute/fu_div_rem.sv
`timescale 1ns/1ps

module fu_div_rem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            rs1_v,
    input  logic [31:0]            rs2_v,
    input  rv32_pkg::decode_info_t info,
    input  logic                   start,
    output logic [31:0]            rd_v,
    output logic                   valid,
    output logic                   busy
);

    logic [31:0] quo_q;
    logic [31:0] rem_q;
    logic [31:0] dvsr_q;
    logic [4:0]  count_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    logic        want_rem_q;

    logic        is_signed;
    logic [31:0] dvnd_abs;
    logic [31:0] dvsr_abs;
    logic [32:0] rem_shift;
    logic [33:0] diff;
    logic        fits;
    logic [31:0] quo_next;
    logic [31:0] rem_next;
    logic [31:0] quo_fix;
    logic [31:0] rem_fix;

    assign is_signed = (info.op.md == rv32_pkg::md_div) ||
                       (info.op.md == rv32_pkg::md_rem);
    assign dvnd_abs  = (is_signed && rs1_v[31]) ? -rs1_v : rs1_v;
    assign dvsr_abs  = (is_signed && rs2_v[31]) ? -rs2_v : rs2_v;

    // One restoring step.
    // The dividend shifts out of quo_q as quotient bits shift in.
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = {1'b0, rem_shift} - {2'b00, dvsr_q};
    assign fits      = !diff[33];
    assign rem_next  = fits ? diff[31:0] : rem_shift[31:0];
    assign quo_next  = {quo_q[30:0], fits};

    assign quo_fix = neg_quo_q ? -quo_next : quo_next;
    assign rem_fix = neg_rem_q ? -rem_next : rem_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            valid   <= 1'b0;
            count_q <= '0;
        end else begin
            valid <= 1'b0;
            if (busy) begin
                count_q <= count_q + 5'd1;
                if (count_q == 5'd31) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end
            end else if (start) begin
                busy    <= 1'b1;
                count_q <= '0;
            end
        end
    end

    // A zero divisor yields all ones and the dividend with no special path,
    // as long as the quotient is not negated. The most negative value over
    // minus one also falls out of the unsigned array unchanged.
    always_ff @(posedge clk) begin
        if (busy) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
            if (count_q == 5'd31) begin
                rd_v <= want_rem_q ? rem_fix : quo_fix;
            end
        end else if (start) begin
            quo_q      <= dvnd_abs;
            rem_q      <= '0;
            dvsr_q     <= dvsr_abs;
            neg_quo_q  <= is_signed && (rs1_v[31] ^ rs2_v[31]) && (rs2_v != '0);
            neg_rem_q  <= is_signed && rs1_v[31];
            want_rem_q <= (info.op.md == rv32_pkg::md_rem) ||
                          (info.op.md == rv32_pkg::md_remu);
        end
    end

    a_no_start_busy : assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    ) else $error("divide started while the divider is busy");

endmodule : fu_div_rem

//--- execute/fu_mult.sv
`timescale 1ns/1ps

module fu_mult #(
    parameter int mul_stages = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            rs1_v,
    input  logic [31:0]            rs2_v,
    input  rv32_pkg::decode_info_t info,
    input  ooo_pkg::tag_t          tag_in,
    input  logic                   start,
    output logic [31:0]            rd_v,
    output ooo_pkg::tag_t          tag_out,
    output logic                   valid
);

    // First stage holds the extended operands.
    typedef struct packed {
        ooo_pkg::tag_t      tag;
        logic               hi;
        logic signed [32:0] a;
        logic signed [32:0] b;
    } opnd_stage_t;

    // Remaining stages carry the finished product.
    typedef struct packed {
        ooo_pkg::tag_t tag;
        logic          hi;
        logic [63:0]   prod;
    } prod_stage_t;

    opnd_stage_t        opnd_d;
    opnd_stage_t        opnd_q;
    logic signed [65:0] prod_full;
    prod_stage_t        pipe [mul_stages-1];
    logic [mul_stages-1:0] v_pipe;
    logic               a_signed;
    logic               b_signed;

    assign a_signed = (info.op.md == rv32_pkg::md_mulh) ||
                      (info.op.md == rv32_pkg::md_mulhsu);
    assign b_signed = (info.op.md == rv32_pkg::md_mulh);

    // A 33-bit signed multiply covers all four signedness combinations.
    always_comb begin
        opnd_d.tag = tag_in;
        opnd_d.hi  = (info.op.md != rv32_pkg::md_mul);
        opnd_d.a   = {a_signed & rs1_v[31], rs1_v};
        opnd_d.b   = {b_signed & rs2_v[31], rs2_v};
    end

    assign prod_full = opnd_q.a * opnd_q.b;

    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[mul_stages-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        opnd_q       <= opnd_d;
        pipe[0].tag  <= opnd_q.tag;
        pipe[0].hi   <= opnd_q.hi;
        pipe[0].prod <= prod_full[63:0];
        for (int i = 1; i < mul_stages - 1; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign valid   = v_pipe[mul_stages-1];
    assign tag_out = pipe[mul_stages-2].tag;
    assign rd_v    = pipe[mul_stages-2].hi ? pipe[mul_stages-2].prod[63:32]
                                           : pipe[mul_stages-2].prod[31:0];

endmodule : fu_mult

//--- execute/fu_add.sv
`timescale 1ns/1ps

module fu_add (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            rs1_v,
    input  logic [31:0]            rs2_v,
    input  rv32_pkg::decode_info_t info,
    input  logic                   start,
    output logic [31:0]            rd_v,
    output logic                   valid
);

    logic [31:0] opnd_b;
    logic [4:0]  shamt;
    logic        do_sub;
    logic [31:0] sum;
    logic [31:0] result;

    assign opnd_b = info.use_imm ? info.imm : rs2_v;
    assign shamt  = opnd_b[4:0];

    // The immediate forms have no sub, so alt only matters for register adds.
    assign do_sub = info.alt && !info.use_imm;
    assign sum    = do_sub ? rs1_v - opnd_b : rs1_v + opnd_b;

    always_comb begin
        case (info.op.alu)
            rv32_pkg::alu_add: begin
                result = sum;
            end
            rv32_pkg::alu_sll: begin
                result = rs1_v << shamt;
            end
            rv32_pkg::alu_slt: begin
                result = {31'b0, $signed(rs1_v) < $signed(opnd_b)};
            end
            rv32_pkg::alu_sltu: begin
                result = {31'b0, rs1_v < opnd_b};
            end
            rv32_pkg::alu_xor: begin
                result = rs1_v ^ opnd_b;
            end
            rv32_pkg::alu_srl: begin
                if (info.alt) begin
                    result = $unsigned($signed(rs1_v) >>> shamt);
                end else begin
                    result = rs1_v >> shamt;
                end
            end
            rv32_pkg::alu_or: begin
                result = rs1_v | opnd_b;
            end
            default: begin
                result = rs1_v & opnd_b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rd_v <= result;
        end
    end

endmodule : fu_add

//--- common/ooo_pkg.sv
package ooo_pkg;

    // Rename tag widths shared by every CDB port.
    localparam int phys_reg_bits = 6;
    localparam int rob_idx_bits  = 6;
    localparam int arch_reg_bits = 5;

    // Identifies where a result belongs in the ROB and the register file.
    typedef struct packed {
        logic [rob_idx_bits-1:0]  rob_idx;
        logic [phys_reg_bits-1:0] pd_s;
        logic [arch_reg_bits-1:0] rd_s;
    } tag_t;

    // One result broadcast on a CDB port.
    // The valid bit is a single-cycle pulse.
    typedef struct packed {
        logic        valid;
        tag_t        tag;
        logic [31:0] rd_v;
    } cdb_t;

endpackage : ooo_pkg

//--- common/rv32_pkg.sv
package rv32_pkg;

    // ALU operations, encoded as funct3 of OP and OP-IMM.
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    // M-extension operations, encoded as funct3 of OP with funct7 = 1.
    typedef enum logic [2:0] {
        md_mul    = 3'b000,
        md_mulh   = 3'b001,
        md_mulhsu = 3'b010,
        md_mulhu  = 3'b011,
        md_div    = 3'b100,
        md_divu   = 3'b101,
        md_rem    = 3'b110,
        md_remu   = 3'b111
    } md_op_e;

    // The same funct3 bits, read by the ALU or by the multiply/divide units.
    typedef union packed {
        alu_op_e alu;
        md_op_e  md;
    } op_u;

    typedef struct packed {
        op_u         op;
        logic        alt;      // funct7 bit 5, sub and sra
        logic        use_imm;
        logic [31:0] imm;
    } decode_info_t;

endpackage : rv32_pkg
